// ==== dv/simt_programs.svh ====
`ifndef SIMT_PROGRAMS_SVH
`define SIMT_PROGRAMS_SVH

localparam int NUM_PROGS = 4;
localparam int MAX_WORDS = 16;
localparam int MAX_CHECKS = 80;

simt_pkg::data_t prog_words [NUM_PROGS][MAX_WORDS];
int prog_size [NUM_PROGS];
int exec_count [NUM_PROGS];
logic expect_illegal [NUM_PROGS];

// one readback check: program, file, register, lane, value
int num_checks;
int chk_prog [MAX_CHECKS];
bit chk_vector [MAX_CHECKS];
int chk_reg [MAX_CHECKS];
int chk_lane [MAX_CHECKS];
simt_pkg::data_t chk_val [MAX_CHECKS];

// instruction encoders
function automatic simt_pkg::data_t enc_r(input bit s, input logic [3:0] f,
        input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2);
    return {3'd1, s, 9'b0, rs2, f, rs1, rd};
endfunction

function automatic simt_pkg::data_t enc_i(input bit s, input logic [3:0] f,
        input logic [4:0] rd, input logic [4:0] rs1, input int imm);
    logic [13:0] imm14;
    imm14 = imm[13:0];
    return {3'd2, s, imm14, f, rs1, rd};
endfunction

function automatic simt_pkg::data_t enc_lui(input bit s, input logic [4:0] rd,
        input logic [19:0] u);
    return {3'd5, u, 3'b0, s, rd};
endfunction

// word offsets
function automatic simt_pkg::data_t enc_jal(input logic [9:0] k);
    return {3'd6, 16'b0, 3'b000, k};
endfunction

function automatic simt_pkg::data_t enc_beqz(input logic [4:0] rs1, input logic [4:0] k);
    return {3'd6, 14'b0, 3'b001, 2'b0, rs1, k};
endfunction

task automatic add_word(input int p, input simt_pkg::data_t w);
    prog_words[p][prog_size[p]] = w;
    prog_size[p]++;
endtask

task automatic add_check(input int p, input bit vec, input int r, input int lane,
        input int val);
    chk_prog[num_checks] = p;
    chk_vector[num_checks] = vec;
    chk_reg[num_checks] = r;
    chk_lane[num_checks] = lane;
    chk_val[num_checks] = simt_pkg::data_t'(val);
    num_checks++;
endtask

task automatic build_programs();
    int a;
    int c;
    int d;
    int u;
    int x;
    num_checks = 0;
    for (int p = 0; p < NUM_PROGS; p++) begin
        prog_size[p] = 0;
        expect_illegal[p] = 1'b0;
    end
    a = int'($urandom % 8192) - 4096;
    c = int'($urandom % 1024);
    d = int'($urandom % 8192) - 4096;
    u = int'($urandom % 1048576);

    // vector arithmetic, v31 gives the lane index
    add_word(0, enc_i(0, 4'b0000, 1, 31, a));
    add_word(0, enc_i(0, 4'b0000, 2, 0, 3));
    add_word(0, enc_r(0, 4'b0000, 3, 1, 2));
    add_word(0, enc_r(0, 4'b0001, 4, 2, 1));
    add_word(0, enc_r(0, 4'b0010, 5, 1, 31));
    add_word(0, enc_r(0, 4'b0100, 6, 31, 2));
    add_word(0, enc_r(0, 4'b0101, 7, 2, 31));
    add_word(0, enc_r(0, 4'b0110, 8, 31, 2));
    add_word(0, enc_r(0, 4'b0111, 9, 31, 0));
    add_word(0, enc_r(0, 4'b1000, 10, 4, 31));
    add_word(0, enc_r(0, 4'b1001, 11, 4, 0));
    add_word(0, enc_i(0, 4'b0010, 12, 31, c));
    add_word(0, enc_i(0, 4'b1010, 13, 1, 4));
    add_word(0, 32'h0);
    exec_count[0] = 14;
    for (int l = 0; l < 4; l++) begin
        x = 3 - (l + a);
        add_check(0, 1, 1, l, l + a);
        add_check(0, 1, 3, l, l + a + 3);
        add_check(0, 1, 4, l, x);
        add_check(0, 1, 5, l, (l + a) * l);
        add_check(0, 1, 6, l, int'(l < 3));
        add_check(0, 1, 7, l, 3 << l);
        add_check(0, 1, 8, l, int'(l == 3));
        add_check(0, 1, 9, l, int'(l != 0));
        add_check(0, 1, 10, l, (x < l) ? x : l);
        add_check(0, 1, 11, l, (x < 0) ? -x : x);
        add_check(0, 1, 12, l, l * c);
        add_check(0, 1, 13, l, (l + a) << 4);
    end

    // scalar against vector destinations, lui
    add_word(1, enc_i(1, 4'b0000, 1, 0, d));
    add_word(1, enc_lui(1, 2, u[19:0]));
    add_word(1, enc_lui(0, 14, 20'h00abc));
    add_word(1, enc_r(1, 4'b0000, 3, 1, 2));
    add_word(1, enc_i(1, 4'b0000, 15, 0, 77));
    add_word(1, 32'h0);
    exec_count[1] = 6;
    add_check(1, 0, 1, 0, d);
    add_check(1, 0, 2, 0, u << 12);
    add_check(1, 0, 3, 0, d + (u << 12));
    add_check(1, 0, 15, 0, 77);
    add_check(1, 0, 14, 0, 0);
    for (int l = 0; l < 4; l++) begin
        add_check(1, 1, 14, l, 32'h00abc000);
        add_check(1, 1, 15, l, 0);
    end

    // control flow, skipped destinations stay zero
    add_word(2, enc_i(1, 4'b0000, 16, 0, 5));
    add_word(2, enc_beqz(16, 3));
    add_word(2, enc_i(0, 4'b0000, 16, 31, 1));
    add_word(2, enc_beqz(0, 2));
    add_word(2, enc_i(0, 4'b0000, 17, 31, 7));
    add_word(2, enc_jal(3));
    add_word(2, enc_i(0, 4'b0000, 18, 31, 7));
    add_word(2, enc_i(0, 4'b0000, 19, 31, 7));
    add_word(2, enc_i(0, 4'b0000, 20, 31, 2));
    add_word(2, 32'h0);
    exec_count[2] = 7;
    add_check(2, 0, 16, 0, 5);
    for (int l = 0; l < 4; l++) begin
        add_check(2, 1, 16, l, l + 1);
        add_check(2, 1, 17, l, 0);
        add_check(2, 1, 18, l, 0);
        add_check(2, 1, 19, l, 0);
        add_check(2, 1, 20, l, l + 2);
    end

    // floating point opcode with rd 22
    add_word(3, {3'd3, 24'b0, 5'd22});
    add_word(3, 32'h0);
    exec_count[3] = 2;
    expect_illegal[3] = 1'b1;
    add_check(3, 0, 22, 0, 0);
    for (int l = 0; l < 4; l++) begin
        add_check(3, 1, 22, l, 0);
    end
endtask

`endif

// ==== dv/simt_core_tb.sv ====
module simt_core_tb;
    timeunit 1ns;
    timeprecision 100ps;

    logic clk;
    logic reset;
    simt_pkg::apb_req_t apb;
    simt_pkg::apb_rsp_t apb_rsp;
    int cycle;
    int access_cycle;
    int mismatches;
    int failures;
    int watchdog_cycles;
    bit table_ready;

    `include "simt_programs.svh"

    simt_core_top #(.NUM_LANES(4), .PROG_DEPTH(64)) DUT (
        .clk     (clk),
        .reset   (reset),
        .apb     (apb),
        .apb_rsp (apb_rsp)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    // setup, access, sample response mid access cycle
    task automatic apb_access(input bit write, input logic [11:0] addr,
            input simt_pkg::data_t wdata, output simt_pkg::data_t rdata, output logic err);
        @(posedge clk);
        apb.psel <= 1'b1;
        apb.penable <= 1'b0;
        apb.pwrite <= write;
        apb.paddr <= addr;
        apb.pwdata <= wdata;
        @(posedge clk);
        apb.penable <= 1'b1;
        @(negedge clk);
        rdata = apb_rsp.prdata;
        err = apb_rsp.pslverr;
        access_cycle = cycle;
        if (apb_rsp.pready !== 1'b1) begin
            $display("pready was not high in the access cycle to address %h", addr);
            failures++;
        end
        @(posedge clk);
        apb.psel <= 1'b0;
        apb.penable <= 1'b0;
    endtask

    task automatic write_expect_ok(input logic [11:0] addr, input simt_pkg::data_t wdata);
        simt_pkg::data_t unused;
        logic err;
        apb_access(1'b1, addr, wdata, unused, err);
        if (err) begin
            $display("write to address %h was refused with pslverr", addr);
            failures++;
        end
    endtask

    task automatic check_value(input string name, input simt_pkg::data_t got,
            input simt_pkg::data_t exp);
        if (got !== exp) begin
            $display("mismatch %s: got %h expected %h", name, got, exp);
            mismatches++;
        end
    endtask

    initial begin
        simt_pkg::data_t rdata;
        logic err;
        int start_cycle;
        int last_busy;
        int run_cycles;
        logic [11:0] addr;
        clk = 1'b0;
        reset = 1'b1;
        cycle = 0;
        mismatches = 0;
        failures = 0;
        apb = '0;
        void'($urandom(32'h99e5a099));
        build_programs();
        watchdog_cycles = 100;
        for (int p = 0; p < NUM_PROGS; p++) begin
            watchdog_cycles += 4 * exec_count[p] + 200 + 3 * prog_size[p];
        end
        watchdog_cycles += 3 * num_checks;
        table_ready = 1'b1;
        repeat (2) @(posedge clk);
        reset <= 1'b0;

        apb_access(1'b0, 12'h104, '0, rdata, err);
        check_value("status after reset", rdata, 32'h0);
        apb_access(1'b0, 12'h300, '0, rdata, err);
        if (!err) begin
            $display("read of unmapped address 300 did not raise pslverr");
            failures++;
        end

        for (int p = 0; p < NUM_PROGS; p++) begin
            for (int w = 0; w < prog_size[p]; w++) begin
                write_expect_ok(12'(4 * w), prog_words[p][w]);
            end
            write_expect_ok(12'h100, 32'h1);
            // cycles counted from the setup cycle of the start write
            start_cycle = access_cycle - 1;
            // second start while running must be refused
            apb_access(1'b1, 12'h100, 32'h1, rdata, err);
            if (!err) begin
                $display("start write while busy did not raise pslverr");
                failures++;
            end
            last_busy = access_cycle - start_cycle;
            do begin
                apb_access(1'b0, 12'h104, '0, rdata, err);
                if (rdata[0]) begin
                    last_busy = access_cycle - start_cycle;
                end
            end while (rdata[0]);
            run_cycles = access_cycle - start_cycle;
            // busy high at every poll before 4n+1, low from then on
            if (last_busy >= 4 * exec_count[p] + 1
                    || run_cycles < 4 * exec_count[p] + 1) begin
                $display("program %0d: busy dropped between cycles %0d and %0d, expected %0d",
                         p, last_busy, run_cycles, 4 * exec_count[p] + 1);
                failures++;
            end
            check_value("status", rdata, {29'b0, expect_illegal[p], 1'b1, 1'b0});
            for (int i = 0; i < num_checks; i++) begin
                if (chk_prog[i] == p) begin
                    if (chk_vector[i]) begin
                        addr = 12'(12'h400 + 16 * chk_reg[i] + 4 * chk_lane[i]);
                    end else begin
                        addr = 12'(12'h200 + 4 * chk_reg[i]);
                    end
                    apb_access(1'b0, addr, '0, rdata, err);
                    check_value($sformatf("%s%0d lane %0d", chk_vector[i] ? "v" : "s",
                                chk_reg[i], chk_lane[i]), rdata, chk_val[i]);
                end
            end
        end

        $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    initial begin
        wait (table_ready);
        repeat (watchdog_cycles) @(posedge clk);
        $display("timeout: run did not finish within %0d cycles", watchdog_cycles);
        $display("Test FAILED");
        $finish;
    end

endmodule

// ==== hdl/host_interface.sv ====
module host_interface #(
    parameter int PROG_DEPTH = simt_pkg::PROG_DEPTH,
    parameter int NUM_LANES = simt_pkg::NUM_LANES,
    parameter type lane_vector_t = simt_pkg::data_t [simt_pkg::NUM_LANES-1:0]
) (
    input  logic                clk,
    input  logic                reset,
    input  simt_pkg::apb_req_t  apb,
    output simt_pkg::apb_rsp_t  apb_rsp,
    input  simt_pkg::pc_t       pc,
    output simt_pkg::data_t     instruction,
    output logic                start,
    input  logic                busy,
    input  logic                halted,
    input  logic                illegal,
    output simt_pkg::reg_addr_t dbg_addr,
    input  simt_pkg::data_t     scalar_rdata,
    input  lane_vector_t        vector_rdata
);
    simt_pkg::data_t prog_mem [PROG_DEPTH];
    simt_pkg::pc_t prog_index;
    logic [1:0] lane;
    logic access;
    logic prog_hit;
    logic ctrl_hit;
    logic status_hit;
    logic scalar_hit;
    logic vector_hit;
    logic illegal_seen;
    logic err;

    assign access = apb.psel && apb.penable;
    assign prog_index = apb.paddr[7:2];
    assign lane = apb.paddr[3:2];

    // address map decode
    assign prog_hit = apb.paddr[11:8] == 4'h0 && int'(prog_index) < PROG_DEPTH;
    assign ctrl_hit = apb.paddr == 12'h100;
    assign status_hit = apb.paddr == 12'h104;
    assign scalar_hit = apb.paddr[11:7] == 5'b00100;
    assign vector_hit = apb.paddr[11:9] == 3'b010 && int'(lane) < NUM_LANES;

    assign instruction = prog_mem[pc];
    assign start = access && apb.pwrite && ctrl_hit && apb.pwdata[0] && !busy;
    assign dbg_addr = scalar_hit ? apb.paddr[6:2] : apb.paddr[8:4];

    always_ff @(posedge clk) begin
        if (access && apb.pwrite && prog_hit && !busy) begin
            prog_mem[prog_index] <= apb.pwdata;
        end
    end

    // sticky until the next run starts
    always_ff @(posedge clk) begin
        if (reset || start) begin
            illegal_seen <= 1'b0;
        end else if (busy && illegal) begin
            illegal_seen <= 1'b1;
        end
    end

    always_comb begin
        apb_rsp.prdata = '0;
        err = 1'b0;
        if (prog_hit) begin
            apb_rsp.prdata = prog_mem[prog_index];
            err = apb.pwrite && busy;
        end else if (ctrl_hit) begin
            err = apb.pwrite && busy;
        end else if (status_hit) begin
            apb_rsp.prdata = {29'b0, illegal_seen, halted, busy};
        end else if (scalar_hit) begin
            apb_rsp.prdata = scalar_rdata;
        end else if (vector_hit) begin
            apb_rsp.prdata = vector_rdata[lane];
        end else begin
            err = 1'b1;
        end
        apb_rsp.pready = 1'b1;
        apb_rsp.pslverr = access && err;
    end

    // controller must take the start and go busy on the next cycle
    a_start_idle: assert property (@(posedge clk) disable iff (reset)
        start |=> busy);

endmodule

// ==== hdl/instr_decoder.sv ====
module instr_decoder (
    input  logic                     clk,
    input  logic                     reset,
    input  simt_pkg::warp_state_e    warp_state,
    input  simt_pkg::data_t          instruction,
    output simt_pkg::decoded_instr_t decoded
);
    simt_pkg::opcode_e opcode;
    logic [3:0] funct4;
    logic [2:0] funct3;
    logic [13:0] imm_i;
    logic [17:0] imm_b;
    logic [19:0] imm_u;
    logic [27:0] imm_j;
    simt_pkg::decoded_instr_t dec_next;

    assign opcode = simt_pkg::opcode_e'(instruction[31:29]);
    assign funct4 = instruction[13:10];
    assign funct3 = instruction[14:12];

    // immediate formats, branch and jump offsets are in bytes
    assign imm_i = instruction[27:14];
    assign imm_b = {instruction[28:19], instruction[13], instruction[4:0], 2'b00};
    assign imm_u = instruction[28:9];
    assign imm_j = {instruction[28:13], instruction[9:0], 2'b00};

    always_comb begin
        dec_next = simt_pkg::DECODED_NOP;
        case (opcode)
            simt_pkg::OPCODE_HALT: dec_next.halt = 1'b1;
            simt_pkg::OPCODE_R: begin
                dec_next.rd = instruction[4:0];
                dec_next.rs1 = instruction[9:5];
                dec_next.rs2 = instruction[18:14];
                dec_next.scalar = instruction[28];
                dec_next.reg_write = 1'b1;
                case (funct4)
                    4'b0000: dec_next.alu_op = simt_pkg::ADD;
                    4'b0001: dec_next.alu_op = simt_pkg::SUB;
                    4'b0010: dec_next.alu_op = simt_pkg::MUL;
                    4'b0100: dec_next.alu_op = simt_pkg::SLT;
                    4'b0101: dec_next.alu_op = simt_pkg::SLL;
                    4'b0110: dec_next.alu_op = simt_pkg::SEQ;
                    4'b0111: dec_next.alu_op = simt_pkg::SNEZ;
                    4'b1000: dec_next.alu_op = simt_pkg::MIN;
                    4'b1001: dec_next.alu_op = simt_pkg::ABS;
                    // div and unknown codes
                    default: begin
                        dec_next.reg_write = 1'b0;
                        dec_next.illegal = 1'b1;
                    end
                endcase
            end
            simt_pkg::OPCODE_I: begin
                dec_next.rd = instruction[4:0];
                dec_next.rs1 = instruction[9:5];
                dec_next.scalar = instruction[28];
                dec_next.immediate = simt_pkg::data_t'($signed(imm_i));
                dec_next.reg_write = 1'b1;
                case (funct4)
                    4'b0000: dec_next.alu_op = simt_pkg::ADDI;
                    4'b0010: dec_next.alu_op = simt_pkg::MULI;
                    4'b1010: dec_next.alu_op = simt_pkg::SLLI;
                    default: begin
                        dec_next.reg_write = 1'b0;
                        dec_next.illegal = 1'b1;
                    end
                endcase
            end
            simt_pkg::OPCODE_UP: begin
                // lui, scalar flag sits in bit 5 here
                dec_next.rd = instruction[4:0];
                dec_next.scalar = instruction[5];
                dec_next.immediate = {imm_u, 12'b0};
                dec_next.reg_src = simt_pkg::IMMEDIATE;
                dec_next.reg_write = 1'b1;
            end
            simt_pkg::OPCODE_J: begin
                dec_next.scalar = 1'b1;
                case (funct3)
                    3'b000: begin
                        dec_next.jump = 1'b1;
                        dec_next.alu_op = simt_pkg::JAL;
                        dec_next.immediate = simt_pkg::data_t'($signed(imm_j));
                    end
                    3'b001: begin
                        dec_next.branch = 1'b1;
                        dec_next.alu_op = simt_pkg::BEQZ;
                        dec_next.rs1 = instruction[9:5];
                        dec_next.rs2 = instruction[18:14];
                        dec_next.immediate = simt_pkg::data_t'($signed(imm_b));
                    end
                    default: dec_next.illegal = 1'b1;
                endcase
            end
            // floating point, loads/stores and spare opcode
            default: dec_next.illegal = 1'b1;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            decoded <= simt_pkg::DECODED_NOP;
        end else if (warp_state == simt_pkg::WARP_DECODE) begin
            decoded <= dec_next;
        end
    end

endmodule

// ==== hdl/lane_alu.sv ====
module lane_alu #(
    parameter int NUM_LANES = simt_pkg::NUM_LANES
) (
    input  logic                            clk,
    input  logic                            reset,
    input  simt_pkg::warp_state_e           warp_state,
    input  simt_pkg::decoded_instr_t        decoded,
    input  simt_pkg::data_t [NUM_LANES-1:0] op_a,
    input  simt_pkg::data_t [NUM_LANES-1:0] op_b,
    output simt_pkg::data_t [NUM_LANES-1:0] result
);
    function automatic simt_pkg::data_t lane_op(
        input simt_pkg::alu_op_e op,
        input simt_pkg::data_t   a,
        input simt_pkg::data_t   b,
        input simt_pkg::data_t   imm
    );
        case (op)
            simt_pkg::ADD:  return a + b;
            simt_pkg::SUB:  return a - b;
            simt_pkg::MUL:  return a * b;
            simt_pkg::SLT:  return simt_pkg::data_t'($signed(a) < $signed(b));
            simt_pkg::SLL:  return a << b[4:0];
            simt_pkg::SEQ:  return simt_pkg::data_t'(a == b);
            simt_pkg::SNEZ: return simt_pkg::data_t'(a != '0);
            simt_pkg::MIN:  return ($signed(a) < $signed(b)) ? a : b;
            simt_pkg::ABS:  return a[simt_pkg::DATA_WIDTH-1] ? -a : a;
            simt_pkg::ADDI: return a + imm;
            simt_pkg::MULI: return a * imm;
            simt_pkg::SLLI: return a << imm[4:0];
            // jal and beqz are resolved by the controller
            default:        return '0;
        endcase
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            result <= '0;
        end else if (warp_state == simt_pkg::WARP_EXECUTE) begin
            for (int l = 0; l < NUM_LANES; l++) begin
                result[l] <= lane_op(decoded.alu_op, op_a[l], op_b[l], decoded.immediate);
            end
        end
    end

endmodule

// ==== hdl/lane_register_file.sv ====
module lane_register_file #(
    parameter type payload_t = simt_pkg::data_t
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                we,
    input  simt_pkg::reg_addr_t waddr,
    input  payload_t            wdata,
    input  simt_pkg::reg_addr_t raddr_a,
    input  simt_pkg::reg_addr_t raddr_b,
    input  simt_pkg::reg_addr_t raddr_dbg,
    output payload_t            rdata_a,
    output payload_t            rdata_b,
    output payload_t            rdata_dbg
);
    payload_t regs [32];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[waddr] <= wdata;
        end
    end

    // combinational reads, operand ports and host readback
    assign rdata_a = regs[raddr_a];
    assign rdata_b = regs[raddr_b];
    assign rdata_dbg = regs[raddr_dbg];

endmodule

// ==== hdl/simt_core_top.sv ====
module simt_core_top #(
    parameter int NUM_LANES = simt_pkg::NUM_LANES,
    parameter int PROG_DEPTH = simt_pkg::PROG_DEPTH
) (
    input  logic               clk,
    input  logic               reset,
    input  simt_pkg::apb_req_t apb,
    output simt_pkg::apb_rsp_t apb_rsp
);
    typedef simt_pkg::data_t [NUM_LANES-1:0] lane_vector_t;

    simt_pkg::decoded_instr_t decoded;
    simt_pkg::warp_state_e warp_state;
    simt_pkg::pc_t pc;
    simt_pkg::data_t instruction;
    simt_pkg::reg_addr_t dbg_addr;
    logic start;
    logic busy;
    logic halted;
    logic scalar_we;
    logic vector_we;
    simt_pkg::data_t scalar_a;
    simt_pkg::data_t scalar_b;
    simt_pkg::data_t scalar_dbg;
    simt_pkg::data_t scalar_wdata;
    lane_vector_t vector_a;
    lane_vector_t vector_b;
    lane_vector_t vector_dbg;
    lane_vector_t vector_wdata;
    lane_vector_t lane_ids;
    lane_vector_t op_a;
    lane_vector_t op_b;
    lane_vector_t alu_result;

    // v31 reads back as the lane index
    for (genvar l = 0; l < NUM_LANES; l++) begin : g_lane_id
        assign lane_ids[l] = simt_pkg::data_t'(l);
    end

    // scalar operands broadcast to every lane
    assign op_a = decoded.scalar ? lane_vector_t'({NUM_LANES{scalar_a}})
                                 : (decoded.rs1 == 5'd31 ? lane_ids : vector_a);
    assign op_b = decoded.scalar ? lane_vector_t'({NUM_LANES{scalar_b}})
                                 : (decoded.rs2 == 5'd31 ? lane_ids : vector_b);

    assign scalar_wdata = decoded.reg_src == simt_pkg::IMMEDIATE ? decoded.immediate
                                                                 : alu_result[0];
    assign vector_wdata = decoded.reg_src == simt_pkg::IMMEDIATE
                          ? lane_vector_t'({NUM_LANES{decoded.immediate}}) : alu_result;

    host_interface #(
        .PROG_DEPTH    (PROG_DEPTH),
        .NUM_LANES     (NUM_LANES),
        .lane_vector_t (lane_vector_t)
    ) u_host (
        .clk          (clk),
        .reset        (reset),
        .apb          (apb),
        .apb_rsp      (apb_rsp),
        .pc           (pc),
        .instruction  (instruction),
        .start        (start),
        .busy         (busy),
        .halted       (halted),
        .illegal      (decoded.illegal),
        .dbg_addr     (dbg_addr),
        .scalar_rdata (scalar_dbg),
        .vector_rdata (dbg_addr == 5'd31 ? lane_ids : vector_dbg)
    );

    warp_controller u_ctrl (
        .clk            (clk),
        .reset          (reset),
        .start          (start),
        .decoded        (decoded),
        .branch_operand (scalar_a),
        .warp_state     (warp_state),
        .pc             (pc),
        .busy           (busy),
        .halted         (halted),
        .scalar_we      (scalar_we),
        .vector_we      (vector_we)
    );

    instr_decoder u_decoder (
        .clk         (clk),
        .reset       (reset),
        .warp_state  (warp_state),
        .instruction (instruction),
        .decoded     (decoded)
    );

    lane_register_file #(.payload_t(simt_pkg::data_t)) u_scalar_rf (
        .clk       (clk),
        .reset     (reset),
        .we        (scalar_we),
        .waddr     (decoded.rd),
        .wdata     (scalar_wdata),
        .raddr_a   (decoded.rs1),
        .raddr_b   (decoded.rs2),
        .raddr_dbg (dbg_addr),
        .rdata_a   (scalar_a),
        .rdata_b   (scalar_b),
        .rdata_dbg (scalar_dbg)
    );

    lane_register_file #(.payload_t(lane_vector_t)) u_vector_rf (
        .clk       (clk),
        .reset     (reset),
        .we        (vector_we),
        .waddr     (decoded.rd),
        .wdata     (vector_wdata),
        .raddr_a   (decoded.rs1),
        .raddr_b   (decoded.rs2),
        .raddr_dbg (dbg_addr),
        .rdata_a   (vector_a),
        .rdata_b   (vector_b),
        .rdata_dbg (vector_dbg)
    );

    lane_alu #(.NUM_LANES(NUM_LANES)) u_alu (
        .clk        (clk),
        .reset      (reset),
        .warp_state (warp_state),
        .decoded    (decoded),
        .op_a       (op_a),
        .op_b       (op_b),
        .result     (alu_result)
    );

endmodule

// ==== hdl/simt_pkg.sv ====
package simt_pkg;

    parameter int DATA_WIDTH = 32;
    parameter int NUM_LANES = 4;
    parameter int PROG_DEPTH = 64;

    typedef logic [DATA_WIDTH-1:0] data_t;
    typedef logic [4:0] reg_addr_t;
    typedef logic [5:0] pc_t;

    // major opcode, instruction bits 31:29
    typedef enum logic [2:0] {
        OPCODE_HALT = 3'd0,
        OPCODE_R    = 3'd1,
        OPCODE_I    = 3'd2,
        OPCODE_F    = 3'd3,
        OPCODE_M    = 3'd4,
        OPCODE_UP   = 3'd5,
        OPCODE_J    = 3'd6
    } opcode_e;

    typedef enum logic [4:0] {
        ADD, SUB, MUL, SLT, SLL, SEQ, SNEZ, MIN, ABS,
        ADDI, MULI, SLLI, JAL, BEQZ
    } alu_op_e;

    typedef enum logic [2:0] {
        WARP_IDLE,
        WARP_FETCH,
        WARP_DECODE,
        WARP_EXECUTE,
        WARP_WRITEBACK
    } warp_state_e;

    typedef enum logic {
        ALU_OUT,
        IMMEDIATE
    } reg_src_e;

    typedef struct packed {
        logic      reg_write;
        logic      branch;
        logic      jump;
        logic      halt;
        logic      illegal;
        logic      scalar;
        reg_src_e  reg_src;
        reg_addr_t rd;
        reg_addr_t rs1;
        reg_addr_t rs2;
        alu_op_e   alu_op;
        data_t     immediate;
    } decoded_instr_t;

    // no-op decode, also the reset value
    parameter decoded_instr_t DECODED_NOP = '{
        reg_write: 1'b0, branch: 1'b0, jump: 1'b0, halt: 1'b0,
        illegal: 1'b0, scalar: 1'b0, reg_src: ALU_OUT,
        rd: '0, rs1: '0, rs2: '0, alu_op: ADDI, immediate: '0
    };

    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [11:0] paddr;
        data_t       pwdata;
    } apb_req_t;

    typedef struct packed {
        data_t prdata;
        logic  pready;
        logic  pslverr;
    } apb_rsp_t;

endpackage

// ==== hdl/warp_controller.sv ====
module warp_controller (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     start,
    input  simt_pkg::decoded_instr_t decoded,
    input  simt_pkg::data_t          branch_operand,
    output simt_pkg::warp_state_e    warp_state,
    output simt_pkg::pc_t            pc,
    output logic                     busy,
    output logic                     halted,
    output logic                     scalar_we,
    output logic                     vector_we
);
    logic redirect;
    logic write_back;

    // jal always, beqz when scalar rs1 is zero
    assign redirect = decoded.jump || (decoded.branch && branch_operand == '0);

    // register 0 never written
    assign write_back = warp_state == simt_pkg::WARP_WRITEBACK && decoded.reg_write
                        && decoded.rd != '0;
    assign scalar_we = write_back && decoded.scalar;
    assign vector_we = write_back && !decoded.scalar;

    always_ff @(posedge clk) begin
        if (reset) begin
            warp_state <= simt_pkg::WARP_IDLE;
            pc <= '0;
            busy <= 1'b0;
            halted <= 1'b0;
        end else begin
            case (warp_state)
                simt_pkg::WARP_IDLE: begin
                    if (start) begin
                        warp_state <= simt_pkg::WARP_FETCH;
                        pc <= '0;
                        busy <= 1'b1;
                        halted <= 1'b0;
                    end
                end
                simt_pkg::WARP_FETCH: warp_state <= simt_pkg::WARP_DECODE;
                simt_pkg::WARP_DECODE: warp_state <= simt_pkg::WARP_EXECUTE;
                simt_pkg::WARP_EXECUTE: begin
                    if (decoded.halt) begin
                        warp_state <= simt_pkg::WARP_IDLE;
                        busy <= 1'b0;
                        halted <= 1'b1;
                    end else begin
                        warp_state <= simt_pkg::WARP_WRITEBACK;
                        // byte offset to word offset
                        if (redirect) begin
                            pc <= pc + simt_pkg::pc_t'(decoded.immediate[31:2]);
                        end
                    end
                end
                simt_pkg::WARP_WRITEBACK: begin
                    warp_state <= simt_pkg::WARP_FETCH;
                    if (!redirect) begin
                        pc <= pc + 1'b1;
                    end
                end
                default: warp_state <= simt_pkg::WARP_IDLE;
            endcase
        end
    end

    a_front_order: assert property (@(posedge clk) disable iff (reset)
        warp_state == simt_pkg::WARP_FETCH |=>
            warp_state == simt_pkg::WARP_DECODE ##1 warp_state == simt_pkg::WARP_EXECUTE);

    a_execute_exit: assert property (@(posedge clk) disable iff (reset)
        warp_state == simt_pkg::WARP_EXECUTE |=>
            warp_state == simt_pkg::WARP_WRITEBACK || (warp_state == simt_pkg::WARP_IDLE && halted));

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the simt core testbench with Verilator
cd "$(dirname "$0")" || exit 1

BUILD_DIR=build
LOG_FILE=$BUILD_DIR/sim.log

mkdir -p "$BUILD_DIR"
if ! verilator --binary --timing -f simt_core_top.f --top-module simt_core_tb \
        -Mdir "$BUILD_DIR/obj"; then
    echo "verilator build failed"
    exit 1
fi

"./$BUILD_DIR/obj/Vsimt_core_tb" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "Test FAILED" "$LOG_FILE"; then
    exit 1
fi
exit 0

// ==== simt_core_top.f ====
+incdir+dv
hdl/simt_pkg.sv
hdl/host_interface.sv
hdl/warp_controller.sv
hdl/instr_decoder.sv
hdl/lane_register_file.sv
hdl/lane_alu.sv
hdl/simt_core_top.sv
dv/simt_core_tb.sv
